// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= uart_link_tb
RTL_TOP   ?= uart_link
FILELIST  ?= uart_link.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/uart_link_tb.sv
// UART link testbench
`timescale 1ns/1ps

module uart_link_tb import uart_pkg::*; ();

    localparam int LOOP_BYTES = 12;
    localparam int NUM_FRAMES = LOOP_BYTES + 3 + FIFO_DEPTH + 1;
    localparam int TIMEOUT_NS = (NUM_FRAMES + 4) * 12 * CLKS_PER_BIT * 10;

    logic        clk;
    logic        reset;
    logic        rxd;
    logic        txd;
    logic        tx_valid;
    byte_t       tx_data;
    logic        tx_credit;
    logic        rx_credit;
    logic        rx_valid;
    byte_t       rx_data;
    logic        rx_parity_error;
    logic        rx_frame_error;
    logic        overrun;
    logic        loopback;            // Route txd back into rxd
    logic        drv_line;            // Frame driver output
    logic [15:0] lfsr_state;
    rx_entry_t   exp_mem [32];        // Scoreboard queue from head to tail
    logic [4:0]  sb_head;
    logic [4:0]  sb_tail;
    int          tx_sent;
    int          tx_returned;
    int          rx_granted;
    int          rx_delivered;
    int          overrun_count;
    logic        overrun_expected;
    int          errors;

    assign rxd = loopback ? txd : drv_line;

    uart_link uart_link_i (
        .clk, .reset, .rxd, .txd, .tx_valid, .tx_data, .tx_credit,
        .rx_credit, .rx_valid, .rx_data, .rx_parity_error, .rx_frame_error, .overrun
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            sb_head       <= '0;
            tx_returned   <= 0;
            rx_delivered  <= 0;
            overrun_count <= 0;
        end else begin
            if (rx_valid) sb_head <= sb_head + 5'd1;
            if (rx_valid) rx_delivered <= rx_delivered + 1;
            if (tx_credit) tx_returned <= tx_returned + 1;
            if (overrun) overrun_count <= overrun_count + 1;
        end
    end

    function automatic void log_mismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    function automatic byte_t random_byte();
        byte_t v;
        int    i;
        v = '0;
        for (i = 0; i < 8; i++) begin
            v          = {lfsr_state[0], v[7:1]};    // First bit taken lands in bit 0
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_entry(input rx_entry_t e);
        exp_mem[sb_tail] = e;
        sb_tail          = sb_tail + 5'd1;
    endtask

    task automatic send_byte(input byte_t b);
        while (tx_sent - tx_returned >= FIFO_DEPTH) step_cycle();    // Wait for a credit
        expect_entry({2'b00, b});
        tx_valid = 1'b1;
        tx_data  = b;
        tx_sent++;
        step_cycle();
        tx_valid = 1'b0;
    endtask

    task automatic grant_credit();
        while (rx_granted - rx_delivered >= FIFO_DEPTH) step_cycle();
        rx_credit = 1'b1;
        rx_granted++;
        step_cycle();
        rx_credit = 1'b0;
    endtask

    task automatic wait_drained();
        while (sb_head != sb_tail) step_cycle();
    endtask

    // Start, 8 data bits LSB first, parity, stop, then one idle bit
    task automatic drive_frame(input byte_t data, input logic bad_parity,
                               input logic low_stop, input int glitch_pos);
        logic [10:0] frame;
        int          b;
        int          c;
        frame = {~low_stop, (^data) ^ PARITY_ODD ^ bad_parity, data, 1'b0};
        for (b = 0; b < 11; b++) begin
            for (c = 0; c < CLKS_PER_BIT; c++) begin
                drv_line = frame[0];
                if (b == glitch_pos && (c == HALF_BIT - 1 || c == HALF_BIT)) begin
                    drv_line = ~frame[0];    // Two-cycle disturbance mid-bit
                end
                step_cycle();
            end
            frame = frame >> 1;
        end
        drv_line = 1'b1;
        repeat (CLKS_PER_BIT) step_cycle();
    endtask

    a_rx_order: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> (sb_head != sb_tail) &&
            ({rx_frame_error, rx_parity_error, rx_data} == exp_mem[sb_head]))
        else log_mismatch("rx entry is not the scoreboard head");

    a_rx_credit: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> rx_granted != rx_delivered)
        else log_mismatch("rx_valid without an outstanding rx credit");

    a_tx_credit: assert property (@(posedge clk) disable iff (reset)
        tx_credit |-> tx_returned < tx_sent)
        else log_mismatch("tx_credit returned without a byte outstanding");

    a_overrun: assert property (@(posedge clk) disable iff (reset)
        overrun |-> overrun_expected)
        else log_mismatch("unexpected overrun pulse");

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: the run timed out after %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int    i;
        byte_t b;
        errors           = 0;
        reset            = 1'b1;
        tx_valid         = 1'b0;
        tx_data          = '0;
        rx_credit        = 1'b0;
        loopback         = 1'b1;
        drv_line         = 1'b1;
        lfsr_state       = 16'd46927;
        sb_tail          = '0;
        tx_sent          = 0;
        rx_granted       = 0;
        overrun_expected = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (txd && !tx_credit && !rx_valid && !overrun)
            else log_mismatch("outputs not idle after reset");

        for (i = 0; i < LOOP_BYTES; i++) begin    // Loopback through the transmitter
            send_byte(random_byte());
            grant_credit();
        end
        wait_drained();
        loopback = 1'b0;

        grant_credit();
        b = random_byte();
        expect_entry({2'b01, b});
        drive_frame(b, 1'b1, 1'b0, -1);           // Inverted parity
        grant_credit();
        b = random_byte();
        expect_entry({2'b10, b});
        drive_frame(b, 1'b0, 1'b1, -1);           // Low stop bit
        wait_drained();

        grant_credit();
        drv_line = 1'b0;                          // One-cycle low on the idle line
        step_cycle();
        drv_line = 1'b1;
        repeat (12 * CLKS_PER_BIT) step_cycle();  // Longer than a full frame
        b = random_byte();
        expect_entry({2'b00, b});
        drive_frame(b, 1'b0, 1'b0, 4);            // Data bit 3 disturbed
        wait_drained();

        overrun_expected = 1'b1;                  // No rx credits outstanding
        for (i = 0; i <= FIFO_DEPTH; i++) begin
            b = random_byte();
            if (i < FIFO_DEPTH) expect_entry({2'b00, b});
            drive_frame(b, 1'b0, 1'b0, -1);
        end
        overrun_expected = 1'b0;
        assert (overrun_count == 1) else log_mismatch("overrun did not pulse exactly once");
        for (i = 0; i < FIFO_DEPTH; i++) grant_credit();
        wait_drained();
        grant_credit();                           // Dropped frame must not appear
        repeat (4 * CLKS_PER_BIT) step_cycle();
        assert (tx_returned == tx_sent) else log_mismatch("tx credit returns differ from bytes sent");

        $display("Summary: %0d errors, %0d entries delivered, %0d overruns",
                 errors, rx_delivered, overrun_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: logic/byte_fifo.sv
// Byte FIFO
`timescale 1ns/1ps

module byte_fifo import uart_pkg::*; (
    input logic       clk,
    input logic       reset,
    byte_fifo_if.fifo fifo
);

    rx_entry_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = fifo.push && !fifo.full;
    assign do_pop  = fifo.pop && !fifo.empty;

    assign fifo.rdata = mem[rd_ptr];
    assign fifo.empty = count == '0;
    assign fifo.full  = count == (PTR_W + 1)'(FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= fifo.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;    // Depth is a power of two
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        fifo.push |-> !fifo.full) else $error("FIFO push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        fifo.pop |-> !fifo.empty) else $error("FIFO pop while empty");

endmodule

// File: logic/byte_fifo_if.sv
// Byte FIFO port bundle
`timescale 1ns/1ps

interface byte_fifo_if import uart_pkg::*; ();

    logic      push;
    rx_entry_t wdata;
    logic      pop;
    rx_entry_t rdata;    // Head entry
    logic      empty;
    logic      full;

    modport writer (output push, output wdata, input full);

    modport reader (output pop, input rdata, input empty);

    modport fifo (input push, input wdata, input pop,
                  output rdata, output empty, output full);

endinterface

// File: logic/link_ctrl.sv
// Link credit and FIFO control
`timescale 1ns/1ps

module link_ctrl import uart_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         tx_valid,
    input  byte_t        tx_data,
    output logic         tx_credit,
    input  logic         rx_credit,
    output logic         rx_valid,
    output byte_t        rx_data,
    output logic         rx_parity_error,
    output logic         rx_frame_error,
    output logic         overrun,
    byte_fifo_if.writer  tx_fifo_w,
    byte_fifo_if.reader  tx_fifo_r,
    byte_fifo_if.writer  rx_fifo_w,
    byte_fifo_if.reader  rx_fifo_r,
    input  logic         rx_done,
    input  rx_entry_t    rx_entry,
    input  logic         tx_ready,
    output logic         tx_start,
    output byte_t        tx_byte
);

    credit_t rx_credits;    // Delivery slots granted by the host

    // Host bytes go straight into the tx FIFO
    assign tx_fifo_w.push  = tx_valid;
    assign tx_fifo_w.wdata = {2'b00, tx_data};

    // Drain to the transmitter, credit back to the host on each take
    assign tx_start       = tx_ready && !tx_fifo_r.empty;
    assign tx_fifo_r.pop  = tx_start;
    assign tx_byte        = tx_fifo_r.rdata[7:0];
    assign tx_credit      = tx_start;

    // Received entries are kept unless the FIFO is full
    assign rx_fifo_w.push  = rx_done && !rx_fifo_w.full;
    assign rx_fifo_w.wdata = rx_entry;

    assign rx_valid        = !rx_fifo_r.empty && (rx_credits != '0);
    assign rx_fifo_r.pop   = rx_valid;
    assign rx_data         = rx_fifo_r.rdata[7:0];
    assign rx_parity_error = rx_fifo_r.rdata[8];
    assign rx_frame_error  = rx_fifo_r.rdata[9];

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_credits <= '0;
            overrun    <= 1'b0;
        end else begin
            overrun <= rx_done && rx_fifo_w.full;    // Entry dropped
            case ({rx_credit, rx_valid})
                2'b10:   rx_credits <= rx_credits + 1'b1;
                2'b01:   rx_credits <= rx_credits - 1'b1;
                default: rx_credits <= rx_credits;
            endcase
        end
    end

    a_tx_credit_respected: assert property (@(posedge clk) disable iff (reset)
        tx_valid |-> !tx_fifo_w.full) else $error("host wrote without a tx credit");

    a_rx_credit_bound: assert property (@(posedge clk) disable iff (reset)
        rx_credits <= credit_t'(FIFO_DEPTH)) else $error("rx credits above FIFO depth");

endmodule

// File: logic/uart_link.sv
// UART link endpoint
`timescale 1ns/1ps

module uart_link import uart_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  rxd,
    output logic  txd,
    input  logic  tx_valid,
    input  byte_t tx_data,
    output logic  tx_credit,
    input  logic  rx_credit,
    output logic  rx_valid,
    output byte_t rx_data,
    output logic  rx_parity_error,
    output logic  rx_frame_error,
    output logic  overrun
);

    logic      rx_done;
    rx_entry_t rx_entry;
    logic      tx_ready;
    logic      tx_start;
    byte_t     tx_byte;

    byte_fifo_if tx_fifo ();    // Host to transmitter
    byte_fifo_if rx_fifo ();    // Receiver to host

    link_ctrl link_ctrl_i (
        .clk, .reset,
        .tx_valid, .tx_data, .tx_credit,
        .rx_credit, .rx_valid, .rx_data, .rx_parity_error, .rx_frame_error, .overrun,
        .tx_fifo_w (tx_fifo), .tx_fifo_r (tx_fifo),
        .rx_fifo_w (rx_fifo), .rx_fifo_r (rx_fifo),
        .rx_done, .rx_entry,
        .tx_ready, .tx_start, .tx_byte
    );

    byte_fifo tx_fifo_i (.clk, .reset, .fifo (tx_fifo));

    byte_fifo rx_fifo_i (.clk, .reset, .fifo (rx_fifo));

    uart_rx uart_rx_i (.clk, .reset, .rxd, .done (rx_done), .entry (rx_entry));

    uart_tx uart_tx_i (
        .clk, .reset,
        .start (tx_start), .data (tx_byte), .ready (tx_ready), .txd
    );

endmodule

// File: logic/uart_pkg.sv
// UART link definitions
package uart_pkg;

    localparam int CLKS_PER_BIT = 8;                // Clock cycles per serial bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2; // Midpoint and vote threshold
    localparam int FIFO_DEPTH   = 4;                // Entries per FIFO
    localparam int PTR_W        = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W     = 3;                // Holds 0 to FIFO_DEPTH
    localparam bit PARITY_ODD   = 1'b0;             // 0 selects even parity

    typedef logic [7:0]          byte_t;
    typedef logic [9:0]          rx_entry_t;        // Frame error, parity error, data
    typedef logic [CREDIT_W-1:0] credit_t;
    typedef logic [3:0]          bit_count_t;
    typedef logic [3:0]          tick_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_CONFIRM,     // Second low sample of the start bit
        RX_START,
        RX_BITS,        // Data bits and parity bit
        RX_STOP,
        RX_DONE         // Wait for the line to return high
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

endpackage

// File: logic/uart_rx.sv
// UART receiver
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      rxd,
    output logic      done,
    output rx_entry_t entry
);

    rx_state_t  state;
    logic       rxd_meta;
    logic       rxd_sync;
    tick_t      tick;
    tick_t      ones;          // High samples seen in the current bit
    bit_count_t bit_idx;
    logic [8:0] shift;         // Parity on top once all bits are in
    tick_t      ones_total;
    logic       bit_val;
    logic       bit_end;
    logic       stop_sample;

    assign ones_total  = ones + tick_t'(rxd_sync);
    assign bit_val     = ones_total > tick_t'(HALF_BIT);    // Ties resolve to zero
    assign bit_end     = tick == tick_t'(CLKS_PER_BIT - 1);
    assign stop_sample = (state == RX_STOP) && (tick == tick_t'(HALF_BIT - 1));

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            tick    <= '0;
            ones    <= '0;
            bit_idx <= '0;
            shift   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rxd_sync) state <= RX_CONFIRM;
                end
                RX_CONFIRM: begin
                    tick  <= '0;
                    state <= rxd_sync ? RX_IDLE : RX_START;    // Single low sample is noise
                end
                RX_START: begin
                    if (tick == tick_t'(CLKS_PER_BIT - 3)) begin    // Two samples already used
                        state   <= RX_BITS;
                        tick    <= '0;
                        ones    <= '0;
                        bit_idx <= '0;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_BITS: begin
                    if (bit_end) begin
                        tick    <= '0;
                        ones    <= '0;
                        shift   <= {bit_val, shift[8:1]};    // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_count_t'(8)) state <= RX_STOP;
                    end else begin
                        tick <= tick + 1'b1;
                        ones <= ones_total;
                    end
                end
                RX_STOP: begin
                    tick <= tick + 1'b1;
                    if (stop_sample) begin
                        done  <= 1'b1;
                        state <= RX_DONE;
                    end
                end
                RX_DONE: begin
                    if (rxd_sync) state <= RX_IDLE;    // Hold off while stop stays low
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stop_sample) begin
            entry <= {~rxd_sync, (^shift) ^ PARITY_ODD, shift[7:0]};
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done) else $error("rx done held for two cycles");

endmodule

// File: logic/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  byte_t data,
    output logic  ready,
    output logic  txd
);

    tx_state_t  state;
    tick_t      tick;
    bit_count_t bit_idx;
    byte_t      shift;
    logic       parity;
    logic       bit_end;

    assign bit_end = tick == tick_t'(CLKS_PER_BIT - 1);
    assign ready   = state == TX_IDLE;

    always_comb begin
        case (state)
            TX_START:  txd = 1'b0;
            TX_DATA:   txd = shift[0];
            TX_PARITY: txd = parity;
            default:   txd = 1'b1;    // Idle and stop
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
        end else begin
            tick <= bit_end ? '0 : tick + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick <= '0;
                    if (start) state <= TX_START;
                end
                TX_START: begin
                    bit_idx <= '0;
                    if (bit_end) state <= TX_DATA;
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_count_t'(7)) state <= TX_PARITY;
                    end
                end
                TX_PARITY: if (bit_end) state <= TX_STOP;
                TX_STOP:   if (bit_end) state <= TX_IDLE;
                default:   state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && ready) begin
            shift  <= data;
            parity <= (^data) ^ PARITY_ODD;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

// File: uart_link.f
logic/uart_pkg.sv
logic/byte_fifo_if.sv
logic/byte_fifo.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/link_ctrl.sv
logic/uart_link.sv
bench/uart_link_tb.sv
